/* files.f */
+incdir+hdl
hdl/axi_rd_pkg.sv
hdl/fetch_pkg.sv
hdl/icache_array.sv
hdl/axi_burst_reader.sv
hdl/ifetch_ctrl.sv
hdl/ifetch_top.sv
sim/tb_clock_gen.sv
sim/axi_mem_model.sv
sim/ifetch_sva.sv
sim/tb_ifetch.sv

/* Bender.yml */
package:
  name: ifetch

export_include_dirs:
  - hdl

sources:
  - hdl/axi_rd_pkg.sv
  - hdl/fetch_pkg.sv
  - hdl/icache_array.sv
  - hdl/axi_burst_reader.sv
  - hdl/ifetch_ctrl.sv
  - hdl/ifetch_top.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/axi_mem_model.sv
      - sim/ifetch_sva.sv
      - sim/tb_ifetch.sv

/* sim/tb_ifetch.sv */
`timescale 1ns/100ps

`include "ifetch_defines.svh"

module tb_ifetch;

  import axi_rd_pkg::*;

  logic        clock;
  logic        reset;
  logic [31:0] npc;
  logic        npc_valid;
  logic        block;
  logic        idu_ready;
  logic        clear_cache;
  logic        clear_pipeline;
  logic [31:0] inst;
  logic [31:0] inst_pc;
  logic        inst_valid;
  logic        misaligned_fault;
  logic [31:0] araddr;
  burst_len_t  arlen;
  logic        arvalid;
  logic        rready;
  logic        arready;
  logic        rvalid;
  logic        rlast;
  beat_t       rdata;
  resp_t       rresp;
  logic        mem_timed_out;

  logic [31:0] rnd;
  int          errors;
  int          checks;
  int          tests;
  logic [31:0] ar_addr_q [$];
  burst_len_t  ar_len_q [$];

  tb_clock_gen i_clock_gen (
    .clock (clock),
    .reset (reset)
  );

  axi_mem_model i_mem (
    .clock     (clock),
    .reset     (reset),
    .araddr    (araddr),
    .arlen     (arlen),
    .arvalid   (arvalid),
    .arready   (arready),
    .rready    (rready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rlast     (rlast),
    .timed_out (mem_timed_out)
  );

  ifetch_top i_dut (
    .clock            (clock),
    .reset            (reset),
    .npc              (npc),
    .npc_valid        (npc_valid),
    .block            (block),
    .idu_ready        (idu_ready),
    .clear_cache      (clear_cache),
    .clear_pipeline   (clear_pipeline),
    .inst             (inst),
    .inst_pc          (inst_pc),
    .inst_valid       (inst_valid),
    .misaligned_fault (misaligned_fault),
    .araddr           (araddr),
    .arlen            (arlen),
    .arvalid          (arvalid),
    .rready           (rready),
    .arready          (arready),
    .rvalid           (rvalid),
    .rlast            (rlast),
    .rdata            (rdata),
    .rresp            (rresp)
  );

  always @(posedge clock) begin
    if (arvalid && arready) begin  // Every accepted read request
      ar_addr_q.push_back(araddr);
      ar_len_q.push_back(arlen);
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] a);
    return a ^ 32'ha5a5_0000;
  endfunction

  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic redirect(input logic [31:0] target);
    ar_addr_q.delete();
    ar_len_q.delete();
    npc            = target;
    clear_pipeline = 1'b1;
    next_cycle();
    clear_pipeline = 1'b0;
  endtask

  // Takes count instructions in order and checks each against the memory contents
  task automatic take_insts(input int count, input logic [31:0] start_pc,
                            input bit random_ready);
    logic [31:0] exp_pc;
    int          n;
    int          waited;
    bit          taken;
    exp_pc = start_pc;
    for (n = 0; n < count; n++) begin
      taken  = 1'b0;
      waited = 0;
      while (!taken && waited < 200) begin
        next_cycle();
        waited++;
        rnd       = xorshift(rnd);
        idu_ready = random_ready ? rnd[7] : 1'b1;
        if (inst_valid && idu_ready) begin
          check_value("inst_pc", inst_pc, exp_pc);
          check_value("inst", inst, mem_word(exp_pc));
          if (n < count - 1) begin
            npc = exp_pc + 32'd4;  // Core confirms the next PC, but not after the last one
          end
          exp_pc = exp_pc + 32'd4;
          taken  = 1'b1;
        end
      end
      if (!taken) begin
        $display("no instruction for pc %h within 200 cycles", exp_pc);
        errors++;
        break;
      end
    end
    idu_ready = 1'b1;
    repeat (10) next_cycle();  // Window for stray read requests
  endtask

  task automatic check_requests(input int count, input logic [31:0] first_addr,
                                input logic [31:0] stride, input logic [31:0] len);
    int i;
    check_value("ar request count", ar_addr_q.size(), count);
    for (i = 0; i < ar_addr_q.size() && i < count; i++) begin
      check_value("araddr", ar_addr_q[i], first_addr + stride * i);
      check_value("arlen", ar_len_q[i], len);
    end
  endtask

  task automatic report_test(input string name, input int start_errors);
    tests++;
    $display("%s: %s, %0d errors", name, (errors == start_errors) ? "pass" : "fail",
             errors - start_errors);
  endtask

  task automatic test_fault();
    int start;
    int cycle;
    int rise;
    start = errors;
    redirect(32'h3000_0102);
    cycle = 0;
    rise  = 0;
    while (rise == 0 && cycle < 200) begin
      block = (cycle == 1 || cycle == 2);  // Two stalled cycles
      next_cycle();
      cycle++;
      if (misaligned_fault) begin
        rise = cycle;
      end
    end
    block = 1'b0;
    if (rise == 0) begin
      $display("misaligned fault never rose within 200 cycles");
    end
    check_value("fault rise cycle", rise, `IFETCH_FAULT_DELAY + 2);
    check_value("inst_pc", inst_pc, 32'h3000_0102);
    check_value("ar request count", ar_addr_q.size(), 0);
    report_test("misaligned fault", start);
  endtask

  initial begin
    int start;
    errors         = 0;
    checks         = 0;
    tests          = 0;
    start          = 0;
    rnd            = 32'd96916;
    npc            = `IFETCH_RESET_PC;
    npc_valid      = 1'b1;
    block          = 1'b0;
    idu_ready      = 1'b1;
    clear_cache    = 1'b0;
    clear_pipeline = 1'b0;
    next_cycle();
    while (reset && start < 200) begin
      next_cycle();
      start++;
    end

    start = errors;
    take_insts(8, `IFETCH_RESET_PC, 1'b0);
    check_requests(2, `IFETCH_RESET_PC, 32'd16, `IFETCH_LINE_WORDS - 1);
    report_test("sequential cached fetch", start);

    start = errors;
    redirect(`IFETCH_RESET_PC);
    take_insts(4, `IFETCH_RESET_PC, 1'b0);
    check_value("ar request count", ar_addr_q.size(), 0);
    report_test("re-fetch hits", start);

    start       = errors;
    clear_cache = 1'b1;
    redirect(`IFETCH_RESET_PC);
    clear_cache = 1'b0;
    take_insts(4, `IFETCH_RESET_PC, 1'b0);
    check_requests(1, `IFETCH_RESET_PC, 32'd16, `IFETCH_LINE_WORDS - 1);
    report_test("flush", start);

    start = errors;
    redirect(32'h0f00_0008);
    take_insts(3, 32'h0f00_0008, 1'b0);
    check_requests(3, 32'h0f00_0008, 32'd4, 32'd0);
    report_test("sram bypass", start);

    test_fault();

    start = errors;
    redirect(32'h3000_0040);
    take_insts(12, 32'h3000_0040, 1'b1);
    check_requests(3, 32'h3000_0040, 32'd16, `IFETCH_LINE_WORDS - 1);
    report_test("decoder back-pressure", start);

    if (reset || mem_timed_out) begin
      $display("reset never released or memory model waited too long for rready");
      errors++;
    end
    if (i_dut.i_sva.failures != 0) begin
      $display("%0d handshake assertions failed", i_dut.i_sva.failures);
      errors += i_dut.i_sva.failures;
    end
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* sim/ifetch_sva.sv */
`timescale 1ns/100ps

module ifetch_sva (
  input logic                   clock,
  input logic                   reset,
  input logic [31:0]            araddr,
  input axi_rd_pkg::burst_len_t arlen,
  input logic                   arvalid,
  input logic                   arready,
  input logic                   rready,
  input logic [31:0]            inst,
  input logic                   inst_valid,
  input logic                   idu_ready
);

  int failures;

  initial failures = 0;

  ar_hold: assert property (@(posedge clock) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen))
    else begin
      $error("read request changed before arready");
      failures++;
    end

  // A redirect may drop the instruction, but it never changes under the decoder
  inst_hold: assert property (@(posedge clock) disable iff (reset)
    inst_valid && !idu_ready |=> !inst_valid || $stable(inst))
    else begin
      $error("instruction changed while the decoder stalled");
      failures++;
    end

  phase_excl: assert property (@(posedge clock) disable iff (reset)
    !(arvalid && rready))
    else begin
      $error("address and data phase overlap");
      failures++;
    end

endmodule

bind ifetch_top ifetch_sva i_sva (
  .clock      (clock),
  .reset      (reset),
  .araddr     (araddr),
  .arlen      (arlen),
  .arvalid    (arvalid),
  .arready    (arready),
  .rready     (rready),
  .inst       (inst),
  .inst_valid (inst_valid),
  .idu_ready  (idu_ready)
);

/* sim/axi_mem_model.sv */
`timescale 1ns/100ps

module axi_mem_model (
  input  logic                   clock,
  input  logic                   reset,
  input  logic [31:0]            araddr,
  input  axi_rd_pkg::burst_len_t arlen,
  input  logic                   arvalid,
  output logic                   arready,
  input  logic                   rready,
  output axi_rd_pkg::beat_t      rdata,
  output axi_rd_pkg::resp_t      rresp,
  output logic                   rvalid,
  output logic                   rlast,
  output logic                   timed_out
);

  import axi_rd_pkg::*;

  logic [31:0] rnd;
  logic [31:0] addr;
  burst_len_t  len;
  int          waited;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  task automatic random_gap();
    rnd = xorshift(rnd);
    repeat (rnd % 3) next_cycle();  // Zero to two idle cycles
  endtask

  initial begin
    rnd       = 32'd96916;
    arready   = 1'b0;
    rvalid    = 1'b0;
    rlast     = 1'b0;
    rdata     = '0;
    rresp     = resp_okay;
    timed_out = 1'b0;
    forever begin
      next_cycle();
      if (!reset && arvalid) begin
        random_gap();
        arready = 1'b1;
        addr    = araddr;
        len     = arlen;
        next_cycle();
        arready = 1'b0;
        for (int beat = 0; beat <= len; beat++) begin
          random_gap();
          rvalid = 1'b1;
          rdata  = (addr + 32'(beat) * 32'd4) ^ 32'ha5a5_0000;  // Incrementing burst
          rlast  = (beat == len);
          waited = 0;
          while (!rready && waited < 200) begin
            next_cycle();
            waited++;
          end
          if (!rready) begin
            timed_out = 1'b1;
          end
          next_cycle();
          rvalid = 1'b0;
          rlast  = 1'b0;
        end
      end
    end
  end

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;  // 10 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clock);
    #1 reset = 1'b0;
  end

endmodule

/* hdl/ifetch_top.sv */
`timescale 1ns/100ps

module ifetch_top (
  input  logic                   clock,
  input  logic                   reset,
  input  logic [31:0]            npc,
  input  logic                   npc_valid,
  input  logic                   block,
  input  logic                   idu_ready,
  input  logic                   clear_cache,
  input  logic                   clear_pipeline,
  output logic [31:0]            inst,
  output logic [31:0]            inst_pc,
  output logic                   inst_valid,
  output logic                   misaligned_fault,
  output logic [31:0]            araddr,
  output axi_rd_pkg::burst_len_t arlen,
  output logic                   arvalid,
  output logic                   rready,
  input  logic                   arready,
  input  logic                   rvalid,
  input  logic                   rlast,
  input  axi_rd_pkg::beat_t      rdata,
  input  axi_rd_pkg::resp_t      rresp
);

  import axi_rd_pkg::*;

  logic [31:0] lookup_pc;
  logic        hit;
  logic [31:0] hit_word;
  logic        flush;
  logic        fill_enable;
  logic        mem_start;
  logic [31:0] mem_addr;
  burst_len_t  mem_len;
  logic        beat_valid;
  logic        beat_last;
  beat_t       beat_data;

  ifetch_ctrl i_ctrl (
    .clock            (clock),
    .reset            (reset),
    .npc              (npc),
    .npc_valid        (npc_valid),
    .block            (block),
    .idu_ready        (idu_ready),
    .clear_cache      (clear_cache),
    .clear_pipeline   (clear_pipeline),
    .inst             (inst),
    .inst_pc          (inst_pc),
    .inst_valid       (inst_valid),
    .misaligned_fault (misaligned_fault),
    .lookup_pc        (lookup_pc),
    .hit              (hit),
    .hit_word         (hit_word),
    .flush            (flush),
    .fill_enable      (fill_enable),
    .mem_start        (mem_start),
    .mem_addr         (mem_addr),
    .mem_len          (mem_len),
    .beat_valid       (beat_valid),
    .beat_last        (beat_last),
    .beat_data        (beat_data)
  );

  icache_array i_cache (
    .clock       (clock),
    .reset       (reset),
    .lookup_pc   (lookup_pc),
    .flush       (flush),
    .fill_enable (fill_enable),
    .beat_valid  (beat_valid),
    .beat_data   (beat_data),
    .hit         (hit),
    .hit_word    (hit_word)
  );

  axi_burst_reader i_reader (
    .clock      (clock),
    .reset      (reset),
    .mem_start  (mem_start),
    .mem_addr   (mem_addr),
    .mem_len    (mem_len),
    .araddr     (araddr),
    .arlen      (arlen),
    .arvalid    (arvalid),
    .arready    (arready),
    .rready     (rready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .rlast      (rlast),
    .beat_valid (beat_valid),
    .beat_last  (beat_last),
    .beat_data  (beat_data)
  );

endmodule

/* hdl/ifetch_ctrl.sv */
`timescale 1ns/100ps

`include "ifetch_defines.svh"

module ifetch_ctrl (
  input  logic                   clock,
  input  logic                   reset,
  input  logic [31:0]            npc,
  input  logic                   npc_valid,
  input  logic                   block,
  input  logic                   idu_ready,
  input  logic                   clear_cache,
  input  logic                   clear_pipeline,
  output logic [31:0]            inst,
  output logic [31:0]            inst_pc,
  output logic                   inst_valid,
  output logic                   misaligned_fault,
  output logic [31:0]            lookup_pc,
  input  logic                   hit,
  input  logic [31:0]            hit_word,
  output logic                   flush,
  output logic                   fill_enable,
  output logic                   mem_start,
  output logic [31:0]            mem_addr,
  output axi_rd_pkg::burst_len_t mem_len,
  input  logic                   beat_valid,
  input  logic                   beat_last,
  input  axi_rd_pkg::beat_t      beat_data
);

  import fetch_pkg::*;
  import axi_rd_pkg::*;

  fetch_state_t                   state;
  logic [31:0]                    pc;
  logic [31:0]                    miss_pc;
  logic                           sram_miss;
  logic                           drop_beat;
  logic                           pipeline_empty;
  logic [`IFETCH_FAULT_DELAY-1:0] fault_line;
  logic                           is_sram;
  logic                           aligned;
  logic                           may_lookup;
  logic                           lookup_hit;
  logic                           spec_ok;
  logic                           fault_now;
  logic                           sram_take;
  logic                           burst_done;

  assign is_sram = (pc[31:24] == `IFETCH_SRAM_REGION);
  assign aligned = (pc[1:0] == 2'b00);

  // A lookup also moves out any instruction the decoder is taking now
  assign may_lookup = (state == st_lookup) && !clear_pipeline && !block &&
                      (idu_ready || !inst_valid);
  assign lookup_hit = hit && !is_sram && aligned;

  // No speculative bus access: the core must have confirmed this PC
  assign spec_ok = pipeline_empty || (npc_valid && (npc == pc));

  assign mem_start = may_lookup && !lookup_hit && spec_ok && aligned;
  assign fault_now = may_lookup && !lookup_hit && spec_ok && !aligned;

  assign burst_done = (state == st_memory) && beat_last;
  assign sram_take  = (state == st_memory) && sram_miss && beat_valid &&
                      !drop_beat && !clear_pipeline;

  // During a burst the cache is indexed by the address being filled
  assign lookup_pc   = (state == st_memory) ? miss_pc : pc;
  assign flush       = clear_cache;
  assign fill_enable = (state == st_memory) && !sram_miss;

  assign mem_addr = is_sram ? pc : {pc[31:`IFETCH_OFFSET_BITS], {`IFETCH_OFFSET_BITS{1'b0}}};
  assign mem_len  = is_sram ? burst_len_t'(0) : burst_len_t'(`IFETCH_LINE_WORDS - 1);

  assign misaligned_fault = fault_line[`IFETCH_FAULT_DELAY-1];

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_lookup;
    end else if (mem_start) begin
      state <= st_memory;
    end else if (burst_done) begin
      state <= st_lookup;  // A burst in flight always runs to its end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc             <= `IFETCH_RESET_PC;
      inst_valid     <= 1'b0;
      pipeline_empty <= 1'b1;
      fault_line     <= '0;
      drop_beat      <= 1'b0;
    end else if (clear_pipeline) begin
      pc             <= npc;
      inst_valid     <= 1'b0;
      pipeline_empty <= 1'b1;
      fault_line     <= '0;
      if (state == st_memory) begin
        drop_beat <= 1'b1;  // SRAM data of the old path must not reach the decoder
      end
    end else begin
      if (idu_ready) begin
        inst_valid <= 1'b0;
      end
      if (!block) begin
        fault_line <= {fault_line[`IFETCH_FAULT_DELAY-2:0], fault_now};
      end
      if (may_lookup && lookup_hit) begin
        inst_valid     <= 1'b1;
        pc             <= pc + 32'd4;
        pipeline_empty <= 1'b0;
      end
      if (mem_start) begin
        drop_beat <= 1'b0;
      end
      if (sram_take) begin
        inst_valid     <= 1'b1;
        pc             <= miss_pc + 32'd4;
        pipeline_empty <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (may_lookup && lookup_hit) begin
      inst    <= hit_word;
      inst_pc <= pc;
    end
    if (fault_now) begin
      inst_pc <= pc;  // Reported with the fault
    end
    if (mem_start) begin
      miss_pc   <= pc;
      sram_miss <= is_sram;
    end
    if (sram_take) begin
      inst    <= beat_data;
      inst_pc <= miss_pc;
    end
  end

endmodule

/* hdl/axi_burst_reader.sv */
`timescale 1ns/100ps

module axi_burst_reader (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   mem_start,
  input  logic [31:0]            mem_addr,
  input  axi_rd_pkg::burst_len_t mem_len,
  output logic [31:0]            araddr,
  output axi_rd_pkg::burst_len_t arlen,
  output logic                   arvalid,
  input  logic                   arready,
  output logic                   rready,
  input  axi_rd_pkg::beat_t      rdata,
  input  axi_rd_pkg::resp_t      rresp,
  input  logic                   rvalid,
  input  logic                   rlast,
  output logic                   beat_valid,
  output logic                   beat_last,
  output axi_rd_pkg::beat_t      beat_data
);

  import axi_rd_pkg::*;

  logic  ar_done;
  logic  r_take;
  resp_t last_resp;

  assign ar_done = arvalid && arready;
  assign r_take  = rready && rvalid;

  assign beat_valid = r_take;
  assign beat_last  = r_take && rlast;
  assign beat_data  = rdata;

  // Address phase first, then the data phase, never both at once
  always_ff @(posedge clock) begin
    if (reset) begin
      arvalid <= 1'b0;
      rready  <= 1'b0;
    end else begin
      if (mem_start) begin
        arvalid <= 1'b1;
      end else if (ar_done) begin
        arvalid <= 1'b0;
        rready  <= 1'b1;
      end
      if (beat_last) begin
        rready <= 1'b0;
      end
    end
  end

  // Request fields are held stable until the slave takes them
  always_ff @(posedge clock) begin
    if (mem_start) begin
      araddr <= mem_addr;
      arlen  <= mem_len;
    end
  end

  // Response codes are kept for debug only, the fetch path ignores them
  always_ff @(posedge clock) begin
    if (r_take) begin
      last_resp <= rresp;
    end
  end

endmodule

/* hdl/icache_array.sv */
`timescale 1ns/100ps

`include "ifetch_defines.svh"

module icache_array (
  input  logic              clock,
  input  logic              reset,
  input  logic [31:0]       lookup_pc,
  input  logic              flush,
  input  logic              fill_enable,
  input  logic              beat_valid,
  input  axi_rd_pkg::beat_t beat_data,
  output logic              hit,
  output logic [31:0]       hit_word
);

  import fetch_pkg::*;

  localparam int lines = 1 << `IFETCH_INDEX_BITS;
  localparam int line_bits = `IFETCH_LINE_WORDS * 32;
  localparam int cnt_bits = $clog2(`IFETCH_LINE_WORDS);

  tag_t                tags [lines];
  line_t               data [lines];
  logic [lines-1:0]    valid;
  logic [cnt_bits-1:0] beat_cnt;
  logic [cnt_bits-1:0] word_sel;
  index_t              index;
  tag_t                pc_tag;
  line_t               line;
  logic                fill;
  logic                first_beat;

  assign index    = lookup_pc[`IFETCH_OFFSET_BITS +: `IFETCH_INDEX_BITS];
  assign pc_tag   = lookup_pc[31 -: `IFETCH_TAG_BITS];
  assign word_sel = lookup_pc[2 +: cnt_bits];
  assign line     = data[index];

  assign hit      = valid[index] && (tags[index] == pc_tag);
  assign hit_word = line[word_sel*32 +: 32];

  assign fill       = fill_enable && beat_valid;
  assign first_beat = (beat_cnt == '0);

  // Beat counter wraps once per line, so it marks the first beat of each fill
  always_ff @(posedge clock) begin
    if (reset) begin
      valid    <= '0;
      beat_cnt <= '0;
    end else begin
      if (fill) begin
        beat_cnt <= beat_cnt + 1'b1;
        if (first_beat) begin
          valid[index] <= 1'b1;
        end
      end
      if (flush) begin
        valid <= '0;  // A flush beats a fill in the same cycle
      end
    end
  end

  // Beats enter at the top word, so after a full burst word 0 sits lowest
  always_ff @(posedge clock) begin
    if (fill) begin
      data[index] <= {beat_data, line[line_bits-1:32]};
      if (first_beat) begin
        tags[index] <= pc_tag;
      end
    end
  end

endmodule

/* hdl/fetch_pkg.sv */
`include "ifetch_defines.svh"

package fetch_pkg;

  // Lookup serves hits from the cache, memory waits on the read burst
  typedef enum logic {
    st_lookup = 1'b0,
    st_memory = 1'b1
  } fetch_state_t;

  // One full cache line, lowest word in the low bits
  typedef logic [`IFETCH_LINE_WORDS*32-1:0] line_t;

  typedef logic [`IFETCH_TAG_BITS-1:0] tag_t;

  typedef logic [`IFETCH_INDEX_BITS-1:0] index_t;

endpackage

/* hdl/axi_rd_pkg.sv */
package axi_rd_pkg;

  typedef logic [7:0] burst_len_t;  // Number of beats minus one

  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_exokay = 2'b01,
    resp_slverr = 2'b10,
    resp_decerr = 2'b11
  } resp_t;

  typedef logic [31:0] beat_t;

endpackage

/* hdl/ifetch_defines.svh */
`ifndef IFETCH_DEFINES_SVH
`define IFETCH_DEFINES_SVH

// Line geometry of the direct-mapped instruction cache
`define IFETCH_OFFSET_BITS 4
`define IFETCH_INDEX_BITS 2
`define IFETCH_LINE_WORDS 4

// Tag is what is left of the PC above index and offset
`define IFETCH_TAG_BITS (32 - `IFETCH_OFFSET_BITS - `IFETCH_INDEX_BITS)

// First fetch address after reset
`define IFETCH_RESET_PC 32'h3000_0000

// Top address byte of the uncached on-chip SRAM
`define IFETCH_SRAM_REGION 8'h0f

// Unstalled cycles between a misaligned PC and the visible fault
`define IFETCH_FAULT_DELAY 4

`endif
